//--- files.f
+incdir+include
src/rx_pkg.sv
src/rx_snapshot.sv
src/rx_frame_sequencer.sv
src/rx_sample_buffer.sv
src/rx_regs.sv
src/rx_audio_buffer.sv
bench/rx_assertions.sv
bench/rx_tb.sv

//--- Bender.yml
package:
  name: rx_audio_buffer

export_include_dirs:
  - include

sources:
  - files:
      - src/rx_pkg.sv
      - src/rx_snapshot.sv
      - src/rx_frame_sequencer.sv
      - src/rx_sample_buffer.sv
      - src/rx_regs.sv
      - src/rx_audio_buffer.sv

  - target: test
    include_dirs:
      - include
    files:
      - bench/rx_assertions.sv
      - bench/rx_tb.sv

//--- bench/rx_tb.sv
// testbench: clock, reset, axi master tasks, lfsr stimulus, frame model, compare tasks, summary
`timescale 1ns/1ps
`include "rx_consts.svh"

module rx_tb;

	localparam int NCHAN   = `RX_NCHAN;
	localparam int XWORDS  = 3 * NCHAN;   // words per transfer
	localparam int LIMIT   = 2000;        // cycles allowed for any single wait
	localparam int SPACING = 20;          // strobe period, above the 3*NCHAN+6 minimum

	logic                    adc_clk;
	logic                    reset_bufs_A;
	logic                    samp_avail;
	rx_pkg::iq_sample_t      chan_iq [NCHAN];
	rx_pkg::ticks_t          ticks;
	logic [`RX_AXI_AW-1:0]   awaddr;
	logic [`RX_AXI_AW-1:0]   araddr;
	logic [`RX_AXI_DW-1:0]   wdata;
	logic [`RX_AXI_DW-1:0]   rdata;
	logic [`RX_AXI_DW/8-1:0] wstrb;
	logic [1:0]              bresp;
	logic [1:0]              rresp;
	logic                    awvalid, awready, wvalid, wready, bvalid, bready;
	logic                    arvalid, arready, rvalid, rready;
	logic                    srq;

	rx_pkg::iq_sample_t samp [16][NCHAN];   // samples of the frame in flight
	rx_pkg::ticks_t     frame_ticks;        // ticks of its last transfer
	int                 nsamps;             // mirror of the NSAMPS register
	logic [15:0]        lfsr;
	rx_pkg::rx_word_t   exp_q [$];
	rx_pkg::rx_word_t   got_q [$];
	int                 errors, tests, tests_failed, faults_at_start;

	always #4 adc_clk = ~adc_clk;   // 8 ns period

	rx_audio_buffer #(.NCHAN(NCHAN)) u_dut (
		.adc_clk         (adc_clk),
		.reset_bufs_A    (reset_bufs_A),
		.samp_avail_i    (samp_avail),
		.chan_iq_i       (chan_iq),
		.ticks_i         (ticks),
		.s_axi_awaddr_i  (awaddr),
		.s_axi_awvalid_i (awvalid),
		.s_axi_awready_o (awready),
		.s_axi_wdata_i   (wdata),
		.s_axi_wstrb_i   (wstrb),
		.s_axi_wvalid_i  (wvalid),
		.s_axi_wready_o  (wready),
		.s_axi_bresp_o   (bresp),
		.s_axi_bvalid_o  (bvalid),
		.s_axi_bready_i  (bready),
		.s_axi_araddr_i  (araddr),
		.s_axi_arvalid_i (arvalid),
		.s_axi_arready_o (arready),
		.s_axi_rdata_o   (rdata),
		.s_axi_rresp_o   (rresp),
		.s_axi_rvalid_o  (rvalid),
		.s_axi_rready_i  (rready),
		.srq_o           (srq)
	);

	// checker sees the sequencer wires inside the top level
	bind rx_audio_buffer rx_assertions u_sva (
		.adc_clk        (adc_clk),
		.reset_bufs_A   (reset_bufs_A),
		.samp_avail_i   (samp_avail_i),
		.wr_en_i        (wr_en),
		.frame_done_i   (frame_done),
		.s_axi_bvalid_i (s_axi_bvalid_o),
		.s_axi_bready_i (s_axi_bready_i),
		.s_axi_bresp_i  (s_axi_bresp_o),
		.s_axi_rvalid_i (s_axi_rvalid_o),
		.s_axi_rready_i (s_axi_rready_i),
		.s_axi_rresp_i  (s_axi_rresp_o),
		.s_axi_rdata_i  (s_axi_rdata_o)
	);

	////////////////////////////////////////////////////////////////////////////
	// stimulus and reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // maximal 16-bit galois taps
	endfunction

	// n fresh bits, one lfsr step each, right aligned
	function automatic logic [47:0] rand_bits(input int n);
		logic [47:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			v    = {v[46:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		rand_bits = v;
	endfunction

	// expected word idx of the frame: channel words by transfer, then ticks and counter
	function automatic rx_pkg::rx_word_t frame_word(input int idx, input rx_pkg::rx_word_t ctr);
		int                 tail;
		rx_pkg::iq_sample_t s;
		tail = idx - nsamps * XWORDS;
		if (tail >= 0)
			case (tail)
				0:       frame_word = frame_ticks[15:0];
				1:       frame_word = frame_ticks[31:16];
				2:       frame_word = frame_ticks[47:32];
				default: frame_word = ctr;   // counter before the increment
			endcase
		else
		begin
			s = samp[idx / XWORDS][(idx % XWORDS) / 3];
			case (idx % 3)
				0:       frame_word = s.i[15:0];
				1:       frame_word = s.q[15:0];
				default: frame_word = {s.i[23:16], s.q[23:16]};
			endcase
		end
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// checks and bookkeeping
	////////////////////////////////////////////////////////////////////////////

	task automatic compare_word(input string name, input rx_pkg::rx_word_t got,
		input rx_pkg::rx_word_t exp);
		if (got !== exp)
		begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_resp(input string name, input rx_pkg::axi_resp_t got,
		input rx_pkg::axi_resp_t exp);
		if (got !== exp)
		begin
			$display("Error at %0t: %s is %s, expected %s", $time, name, got.name(), exp.name());
			errors++;
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	function automatic int fault_count();
		fault_count = errors + u_dut.u_sva.fails;   // assertion failures count too
	endfunction

	task automatic end_test(input string name);
		tests++;
		if (fault_count() == faults_at_start)
			$display("test %0d, %s: ok", tests, name);
		else
		begin
			tests_failed++;
			$display("test %0d, %s: FAILED", tests, name);
		end
		faults_at_start = fault_count();
	endtask

	task automatic give_up(input string what);
		$display("timeout: no %s within %0d cycles", what, LIMIT);
		$display("tests failed");
		$finish;
	endtask

	// pops compared in order against the model
	always @(negedge adc_clk)
		while (got_q.size() > 0)
			compare_word("s_axi_rdata_o", got_q.pop_front(), exp_q.pop_front());

	////////////////////////////////////////////////////////////////////////////
	// axi master
	////////////////////////////////////////////////////////////////////////////

	task automatic axi_write(input logic [`RX_AXI_AW-1:0] addr, input logic [31:0] data,
		output rx_pkg::axi_resp_t resp);
		int n;
		@(negedge adc_clk);
		awaddr  = addr;
		wdata   = data;
		wstrb   = '1;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		n       = 0;
		#1;                                    // ready settles after the drive
		while (!(awready && wready) && n < LIMIT)
		begin
			@(negedge adc_clk);
			#1;
			n++;
		end
		if (!(awready && wready)) give_up("write address and data handshake");
		@(negedge adc_clk);                    // taken on the edge in between
		awvalid = 1'b0;
		wvalid  = 1'b0;
		n       = 0;
		while (!bvalid && n < LIMIT)
		begin
			@(negedge adc_clk);
			n++;
		end
		if (!bvalid) give_up("write response");
		resp   = rx_pkg::axi_resp_t'(bresp);
		bready = 1'b1;
		@(negedge adc_clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [`RX_AXI_AW-1:0] addr, output logic [31:0] data,
		output rx_pkg::axi_resp_t resp);
		int n;
		@(negedge adc_clk);
		araddr  = addr;
		arvalid = 1'b1;
		n       = 0;
		#1;
		while (!arready && n < LIMIT)
		begin
			@(negedge adc_clk);
			#1;
			n++;
		end
		if (!arready) give_up("read address handshake");
		@(negedge adc_clk);
		arvalid = 1'b0;
		n       = 0;
		while (!rvalid && n < LIMIT)
		begin
			@(negedge adc_clk);
			n++;
		end
		if (!rvalid) give_up("read data");
		data = rdata;
		resp = rx_pkg::axi_resp_t'(rresp);
		@(negedge adc_clk);                    // leave the response waiting one cycle
		rready = 1'b1;
		@(negedge adc_clk);
		rready = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// frame level tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic send_frame();
		logic [47:0] v;
		int          n;
		for (int x = 0; x < nsamps; x++)
		begin
			@(negedge adc_clk);
			for (int c = 0; c < NCHAN; c++)
			begin
				v              = rand_bits(`RX_SAMP_W);
				samp[x][c].i   = v[`RX_SAMP_W-1:0];
				v              = rand_bits(`RX_SAMP_W);
				samp[x][c].q   = v[`RX_SAMP_W-1:0];
				chan_iq[c]     = samp[x][c];
			end
			frame_ticks = rand_bits(`RX_TICKS_W);
			ticks       = frame_ticks;
			samp_avail  = 1'b1;
			@(negedge adc_clk);
			samp_avail  = 1'b0;
			repeat (SPACING - 1) @(negedge adc_clk);
		end
		n = 0;
		while (!srq && n < LIMIT)
		begin
			@(negedge adc_clk);
			n++;
		end
		if (!srq) give_up("service request after the frame");
	endtask

	task automatic read_frame(input rx_pkg::rx_word_t ctr);
		logic [31:0]       data;
		rx_pkg::axi_resp_t resp;
		for (int k = 0; k < nsamps * XWORDS + 4; k++)
		begin
			axi_read(`RX_REG_SAMPLE, data, resp);
			compare_resp("s_axi_rresp_o", resp, rx_pkg::AXI_OKAY);
			exp_q.push_back(frame_word(k, ctr));
			got_q.push_back(data[15:0]);
		end
		repeat (2) @(negedge adc_clk);        // comparer drains the queues
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [31:0]       data;
		rx_pkg::axi_resp_t resp;
		adc_clk      = 1'b0;
		reset_bufs_A = 1'b1;
		samp_avail   = 1'b0;
		for (int c = 0; c < NCHAN; c++) chan_iq[c] = '0;
		ticks   = '0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		lfsr    = 16'd44621;
		nsamps  = `RX_NSAMPS_RESET;
		errors          = 0;
		tests           = 0;
		tests_failed    = 0;
		faults_at_start = 0;
		repeat (5) @(posedge adc_clk);
		@(negedge adc_clk);
		reset_bufs_A = 1'b0;

		// register values out of reset
		axi_read(`RX_REG_NSAMPS, data, resp);
		compare_resp("s_axi_rresp_o", resp, rx_pkg::AXI_OKAY);
		compare_word("nsamps", data[15:0], `RX_NSAMPS_RESET);
		axi_read(`RX_REG_STATUS, data, resp);
		compare_resp("s_axi_rresp_o", resp, rx_pkg::AXI_OKAY);
		compare_flag("status srq", data[0], 1'b0);
		axi_read(`RX_REG_BUFCTR, data, resp);
		compare_resp("s_axi_rresp_o", resp, rx_pkg::AXI_OKAY);
		compare_word("buf_ctr", data[15:0], 16'd0);
		end_test("reset values");

		axi_write(`RX_REG_NSAMPS, 32'd3, resp);
		compare_resp("s_axi_bresp_o", resp, rx_pkg::AXI_OKAY);
		nsamps = 3;
		axi_read(`RX_REG_NSAMPS, data, resp);
		compare_word("nsamps", data[15:0], 16'd3);
		end_test("nsamps write");

		send_frame();
		read_frame(16'd0);
		end_test("first frame");

		axi_read(`RX_REG_STATUS, data, resp);
		compare_flag("status srq", data[0], 1'b1);
		compare_flag("srq_o", srq, 1'b0);     // cleared by that read
		axi_read(`RX_REG_STATUS, data, resp);
		compare_flag("status srq", data[0], 1'b0);
		axi_read(`RX_REG_BUFCTR, data, resp);
		compare_word("buf_ctr", data[15:0], 16'd1);
		end_test("service request clear");

		// 22 + 3*82 words, both pointers pass 256
		axi_write(`RX_REG_NSAMPS, 32'd13, resp);
		compare_resp("s_axi_bresp_o", resp, rx_pkg::AXI_OKAY);
		nsamps = 13;
		for (int f = 1; f <= 3; f++)
		begin
			send_frame();
			read_frame(rx_pkg::rx_word_t'(f));
			axi_read(`RX_REG_STATUS, data, resp);
			compare_flag("status srq", data[0], 1'b1);
		end
		axi_read(`RX_REG_BUFCTR, data, resp);
		compare_word("buf_ctr", data[15:0], 16'd4);
		end_test("wrapping frames");

		axi_write(5'h10, 32'hFFFF_FFFF, resp);
		compare_resp("s_axi_bresp_o", resp, rx_pkg::AXI_SLVERR);
		axi_read(5'h10, data, resp);
		compare_resp("s_axi_rresp_o", resp, rx_pkg::AXI_SLVERR);
		compare_word("s_axi_rdata_o[15:0]", data[15:0], 16'd0);
		compare_word("s_axi_rdata_o[31:16]", data[31:16], 16'd0);
		end_test("unknown address");

		repeat (4) @(negedge adc_clk);
		$display("%0d tests, %0d passed, %0d failed, %0d check errors", tests,
			tests - tests_failed, tests_failed, fault_count());
		if (fault_count() == 0 && tests_failed == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- bench/rx_assertions.sv
// concurrent checks: axi response hold, strobe spacing, write bursts, frame done
`timescale 1ns/1ps
`include "rx_consts.svh"

module rx_assertions (
	input logic                  adc_clk,
	input logic                  reset_bufs_A,
	input logic                  samp_avail_i,
	input logic                  wr_en_i,        // sequencer memory write
	input logic                  frame_done_i,
	input logic                  s_axi_bvalid_i,
	input logic                  s_axi_bready_i,
	input logic [1:0]            s_axi_bresp_i,
	input logic                  s_axi_rvalid_i,
	input logic                  s_axi_rready_i,
	input logic [1:0]            s_axi_rresp_i,
	input logic [`RX_AXI_DW-1:0] s_axi_rdata_i
);

	localparam int GAP = 3 * `RX_NCHAN + 5;   // quiet cycles after a strobe

	int fails;   // read by the testbench summary

	initial fails = 0;

	// a response stays put until the master takes it
	a_b_hold: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
		s_axi_bvalid_i && !s_axi_bready_i |=> s_axi_bvalid_i && $stable(s_axi_bresp_i))
		else begin fails++; $error("write response changed before bready"); end

	a_r_hold: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
		s_axi_rvalid_i && !s_axi_rready_i |=>
		s_axi_rvalid_i && $stable(s_axi_rresp_i) && $stable(s_axi_rdata_i))
		else begin fails++; $error("read response changed before rready"); end

	a_spacing: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
		samp_avail_i |=> !samp_avail_i [*GAP])
		else begin fails++; $error("sample strobes closer than the minimum"); end

	// idle only leaves on a strobe, so every burst starts one cycle after one
	a_no_idle_write: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
		$rose(wr_en_i) |-> $past(samp_avail_i))
		else begin fails++; $error("memory write without a strobe"); end

	a_done_alone: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
		frame_done_i |-> !wr_en_i)
		else begin fails++; $error("frame done during a memory write"); end

endmodule

//--- src/rx_audio_buffer.sv
// audio buffer top: sample snapshots, packing sequencer, sample memory, axi registers
`timescale 1ns/1ps
`include "rx_consts.svh"

module rx_audio_buffer #(
	parameter int NCHAN = `RX_NCHAN
) (
	input  logic                    adc_clk,
	input  logic                    reset_bufs_A,     // also the buffer reset command
	input  logic                    samp_avail_i,
	input  rx_pkg::iq_sample_t      chan_iq_i [NCHAN],
	input  rx_pkg::ticks_t          ticks_i,
	input  logic [`RX_AXI_AW-1:0]   s_axi_awaddr_i,
	input  logic                    s_axi_awvalid_i,
	output logic                    s_axi_awready_o,
	input  logic [`RX_AXI_DW-1:0]   s_axi_wdata_i,
	input  logic [`RX_AXI_DW/8-1:0] s_axi_wstrb_i,
	input  logic                    s_axi_wvalid_i,
	output logic                    s_axi_wready_o,
	output logic [1:0]              s_axi_bresp_o,
	output logic                    s_axi_bvalid_o,
	input  logic                    s_axi_bready_i,
	input  logic [`RX_AXI_AW-1:0]   s_axi_araddr_i,
	input  logic                    s_axi_arvalid_i,
	output logic                    s_axi_arready_o,
	output logic [`RX_AXI_DW-1:0]   s_axi_rdata_o,
	output logic [1:0]              s_axi_rresp_o,
	output logic                    s_axi_rvalid_o,
	input  logic                    s_axi_rready_i,
	output logic                    srq_o
);

	rx_pkg::rx_word_t  chan_word [NCHAN];   // selected word of each channel
	rx_pkg::rx_word_t  ticks_word;
	rx_pkg::word_sel_t word_sel;
	rx_pkg::rx_word_t  wr_data;
	rx_pkg::rx_word_t  buf_ctr;
	rx_pkg::rx_word_t  rd_data;
	rx_pkg::nsamps_t   nsamps;
	logic              wr_en;
	logic              frame_done;
	logic              rd_pop;

	// one latch per channel, all on the same strobe
	for (genvar c = 0; c < NCHAN; c++)
	begin : g_chan
		rx_snapshot #(.payload_t(rx_pkg::iq_sample_t)) u_iq_snap (
			.adc_clk      (adc_clk),
			.reset_bufs_A (reset_bufs_A),
			.capture_i    (samp_avail_i),
			.payload_i    (chan_iq_i[c]),
			.word_sel_i   (word_sel),
			.word_o       (chan_word[c])
		);
	end

	rx_snapshot #(.payload_t(rx_pkg::ticks_t)) u_ticks_snap (
		.adc_clk      (adc_clk),
		.reset_bufs_A (reset_bufs_A),
		.capture_i    (samp_avail_i),
		.payload_i    (ticks_i),
		.word_sel_i   (word_sel),
		.word_o       (ticks_word)
	);

	rx_frame_sequencer #(.NCHAN(NCHAN)) u_seq (
		.adc_clk      (adc_clk),
		.reset_bufs_A (reset_bufs_A),
		.samp_avail_i (samp_avail_i),
		.nsamps_i     (nsamps),
		.chan_word_i  (chan_word),
		.ticks_word_i (ticks_word),
		.word_sel_o   (word_sel),
		.wr_en_o      (wr_en),
		.wr_data_o    (wr_data),
		.buf_ctr_o    (buf_ctr),
		.frame_done_o (frame_done)
	);

	rx_sample_buffer #(.ADDR_W(`RX_BUF_AW)) u_buf (
		.adc_clk      (adc_clk),
		.reset_bufs_A (reset_bufs_A),
		.wr_en_i      (wr_en),
		.wr_data_i    (wr_data),
		.rd_pop_i     (rd_pop),
		.rd_data_o    (rd_data)
	);

	rx_regs u_regs (
		.adc_clk         (adc_clk),
		.reset_bufs_A    (reset_bufs_A),
		.s_axi_awaddr_i  (s_axi_awaddr_i),
		.s_axi_awvalid_i (s_axi_awvalid_i),
		.s_axi_awready_o (s_axi_awready_o),
		.s_axi_wdata_i   (s_axi_wdata_i),
		.s_axi_wstrb_i   (s_axi_wstrb_i),
		.s_axi_wvalid_i  (s_axi_wvalid_i),
		.s_axi_wready_o  (s_axi_wready_o),
		.s_axi_bresp_o   (s_axi_bresp_o),
		.s_axi_bvalid_o  (s_axi_bvalid_o),
		.s_axi_bready_i  (s_axi_bready_i),
		.s_axi_araddr_i  (s_axi_araddr_i),
		.s_axi_arvalid_i (s_axi_arvalid_i),
		.s_axi_arready_o (s_axi_arready_o),
		.s_axi_rdata_o   (s_axi_rdata_o),
		.s_axi_rresp_o   (s_axi_rresp_o),
		.s_axi_rvalid_o  (s_axi_rvalid_o),
		.s_axi_rready_i  (s_axi_rready_i),
		.buf_ctr_i       (buf_ctr),
		.frame_done_i    (frame_done),
		.rd_data_i       (rd_data),
		.nsamps_o        (nsamps),
		.rd_pop_o        (rd_pop),
		.srq_o           (srq_o)
	);

endmodule

//--- src/rx_regs.sv
// axi4-lite register block: sample count, service request, buffer counter, sample pop window
`timescale 1ns/1ps
`include "rx_consts.svh"

module rx_regs (
	input  logic                    adc_clk,
	input  logic                    reset_bufs_A,
	input  logic [`RX_AXI_AW-1:0]   s_axi_awaddr_i,
	input  logic                    s_axi_awvalid_i,
	output logic                    s_axi_awready_o,
	input  logic [`RX_AXI_DW-1:0]   s_axi_wdata_i,
	input  logic [`RX_AXI_DW/8-1:0] s_axi_wstrb_i,
	input  logic                    s_axi_wvalid_i,
	output logic                    s_axi_wready_o,
	output logic [1:0]              s_axi_bresp_o,
	output logic                    s_axi_bvalid_o,
	input  logic                    s_axi_bready_i,
	input  logic [`RX_AXI_AW-1:0]   s_axi_araddr_i,
	input  logic                    s_axi_arvalid_i,
	output logic                    s_axi_arready_o,
	output logic [`RX_AXI_DW-1:0]   s_axi_rdata_o,
	output logic [1:0]              s_axi_rresp_o,
	output logic                    s_axi_rvalid_o,
	input  logic                    s_axi_rready_i,
	input  rx_pkg::rx_word_t        buf_ctr_i,
	input  logic                    frame_done_i,
	input  rx_pkg::rx_word_t        rd_data_i,
	output rx_pkg::nsamps_t         nsamps_o,
	output logic                    rd_pop_o,
	output logic                    srq_o
);

	logic                  bvalid_q, rvalid_q;
	logic                  rd_pend_q;           // memory read cycle
	logic [`RX_AXI_AW-1:0] rd_addr_q;
	logic [`RX_AXI_DW-1:0] rdata_q;
	rx_pkg::axi_resp_t     bresp_q, rresp_q;
	rx_pkg::nsamps_t       nsamps_q;
	logic                  srq_q;
	logic                  busy, wr_go, rd_go, status_rd;

	function automatic logic is_reg(input logic [`RX_AXI_AW-1:0] addr);
		is_reg = (addr == `RX_REG_NSAMPS) || (addr == `RX_REG_STATUS) ||
			(addr == `RX_REG_BUFCTR) || (addr == `RX_REG_SAMPLE);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// handshakes, one transaction in flight
	////////////////////////////////////////////////////////////////////////////

	assign busy  = bvalid_q | rvalid_q | rd_pend_q;
	assign wr_go = s_axi_awvalid_i & s_axi_wvalid_i & ~busy;    // aw and w taken together
	assign rd_go = s_axi_arvalid_i & ~busy & ~wr_go;            // write wins a tie

	assign s_axi_awready_o = wr_go;
	assign s_axi_wready_o  = wr_go;
	assign s_axi_arready_o = rd_go;

	assign rd_pop_o  = rd_go & (s_axi_araddr_i == `RX_REG_SAMPLE);  // word lands in the pend cycle
	assign status_rd = rd_pend_q & (rd_addr_q == `RX_REG_STATUS);

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			bvalid_q  <= 1'b0;
			rvalid_q  <= 1'b0;
			rd_pend_q <= 1'b0;
			srq_q     <= 1'b0;
			nsamps_q  <= rx_pkg::nsamps_t'(`RX_NSAMPS_RESET);
		end
		else
		begin
			if (wr_go)
				bvalid_q <= 1'b1;
			else if (s_axi_bready_i)
				bvalid_q <= 1'b0;

			rd_pend_q <= rd_go;
			if (rd_pend_q)
				rvalid_q <= 1'b1;
			else if (s_axi_rready_i)
				rvalid_q <= 1'b0;

			if (wr_go && (s_axi_awaddr_i == `RX_REG_NSAMPS) && s_axi_wstrb_i[0])
				nsamps_q <= rx_pkg::nsamps_t'(s_axi_wdata_i[7:0]);

			srq_q <= frame_done_i | (srq_q & ~status_rd);   // a new frame beats the clear
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// response payload
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge adc_clk)
	begin
		if (wr_go)
		begin
			if (is_reg(s_axi_awaddr_i))
				bresp_q <= rx_pkg::AXI_OKAY;    // read-only registers ignore the data
			else
				bresp_q <= rx_pkg::AXI_SLVERR;
		end
		if (rd_go) rd_addr_q <= s_axi_araddr_i;
		if (rd_pend_q)
		begin
			rresp_q <= rx_pkg::AXI_OKAY;
			case (rd_addr_q)
				`RX_REG_NSAMPS: rdata_q <= {{(`RX_AXI_DW-`RX_NSAMPS_W){1'b0}}, nsamps_q};
				`RX_REG_STATUS: rdata_q <= {{(`RX_AXI_DW-1){1'b0}}, srq_q};
				`RX_REG_BUFCTR: rdata_q <= {{(`RX_AXI_DW-`RX_WORD_W){1'b0}}, buf_ctr_i};
				`RX_REG_SAMPLE: rdata_q <= {{(`RX_AXI_DW-`RX_WORD_W){1'b0}}, rd_data_i};
				default:
				begin
					rdata_q <= '0;
					rresp_q <= rx_pkg::AXI_SLVERR;
				end
			endcase
		end
	end

	assign s_axi_bvalid_o = bvalid_q;
	assign s_axi_bresp_o  = bresp_q;
	assign s_axi_rvalid_o = rvalid_q;
	assign s_axi_rresp_o  = rresp_q;
	assign s_axi_rdata_o  = rdata_q;
	assign nsamps_o       = nsamps_q;
	assign srq_o          = srq_q;

endmodule

//--- src/rx_sample_buffer.sv
// sample memory with wrapping write and read pointers, registered pop port
`timescale 1ns/1ps
`include "rx_consts.svh"

module rx_sample_buffer #(
	parameter int ADDR_W = `RX_BUF_AW
) (
	input  logic             adc_clk,
	input  logic             reset_bufs_A,
	input  logic             wr_en_i,
	input  rx_pkg::rx_word_t wr_data_i,
	input  logic             rd_pop_i,    // one word per pulse
	output rx_pkg::rx_word_t rd_data_o
);

	rx_pkg::rx_word_t  mem [2**ADDR_W];
	logic [ADDR_W-1:0] wr_ptr_q;
	logic [ADDR_W-1:0] rd_ptr_q;

	// both pointers wrap on their own, no full or empty tracking
	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end
		else
		begin
			if (wr_en_i)  wr_ptr_q <= wr_ptr_q + 1'b1;
			if (rd_pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
		end
	end

	always_ff @(posedge adc_clk)
		if (wr_en_i) mem[wr_ptr_q] <= wr_data_i;

	// data valid the cycle after the pop
	always_ff @(posedge adc_clk)
		if (rd_pop_i) rd_data_o <= mem[rd_ptr_q];

endmodule

//--- src/rx_frame_sequencer.sv
// packing fsm: channel words, tick words and buffer counter into the sample memory
`timescale 1ns/1ps
`include "rx_consts.svh"

module rx_frame_sequencer #(
	parameter int NCHAN = `RX_NCHAN
) (
	input  logic              adc_clk,
	input  logic              reset_bufs_A,
	input  logic              samp_avail_i,
	input  rx_pkg::nsamps_t   nsamps_i,
	input  rx_pkg::rx_word_t  chan_word_i [NCHAN],
	input  rx_pkg::rx_word_t  ticks_word_i,
	output rx_pkg::word_sel_t word_sel_o,
	output logic              wr_en_o,
	output rx_pkg::rx_word_t  wr_data_o,
	output rx_pkg::rx_word_t  buf_ctr_o,
	output logic              frame_done_o
);

	localparam int CHW = (NCHAN > 1) ? $clog2(NCHAN) : 1;

	// S_CHAN   i, q, iq-high per channel, one word a cycle
	// S_TAIL   ticks 0..2 in phase 0..2, counter word in phase 3
	// S_FINISH counter word is being written, bump counter
	typedef enum logic [1:0] {S_IDLE, S_CHAN, S_TAIL, S_FINISH} state_t;

	state_t            state_q, state_d;
	logic [CHW-1:0]    chan_q, chan_d;      // channel being packed
	rx_pkg::word_sel_t phase_q, phase_d;    // word within channel or tail
	rx_pkg::nsamps_t   count_q, count_d;    // transfers done in this frame
	rx_pkg::rx_word_t  buf_ctr_q;
	rx_pkg::rx_word_t  next_word;
	logic              wr_en_d, inc_d;
	logic              wr_en_q, frame_done_q;
	logic              step, last_chan, last_xfer;

	assign step      = (state_q == S_CHAN) | samp_avail_i;   // idle only moves on the strobe
	assign last_chan = (chan_q == CHW'(NCHAN - 1));
	assign last_xfer = (count_q == rx_pkg::nsamps_t'(nsamps_i - 1'b1));

	////////////////////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		state_d = state_q;
		chan_d  = chan_q;
		phase_d = phase_q;
		count_d = count_q;
		wr_en_d = 1'b0;
		inc_d   = 1'b0;
		case (state_q)
			S_IDLE, S_CHAN:
			begin
				if (step)
				begin
					wr_en_d = 1'b1;
					state_d = S_CHAN;
					if (phase_q == 2'd2)    // iq-high done, next channel
					begin
						phase_d = '0;
						if (last_chan)
						begin
							chan_d = '0;
							if (last_xfer)
								state_d = S_TAIL;   // frame full, append ticks and counter
							else
							begin
								count_d = rx_pkg::nsamps_t'(count_q + 1'b1);
								state_d = S_IDLE;   // wait for the next strobe
							end
						end
						else
							chan_d = chan_q + 1'b1;
					end
					else
						phase_d = phase_q + 1'b1;
				end
			end
			S_TAIL:
			begin
				wr_en_d = 1'b1;
				if (phase_q == 2'd3)
				begin
					phase_d = '0;
					state_d = S_FINISH;
				end
				else
					phase_d = phase_q + 1'b1;
			end
			default:    // S_FINISH
			begin
				inc_d   = 1'b1;
				count_d = '0;
				state_d = S_IDLE;
			end
		endcase
	end

	// word for the next write, counter goes out before its increment
	always_comb
		if (state_q == S_TAIL)
			next_word = (phase_q == 2'd3) ? buf_ctr_q : ticks_word_i;
		else
			next_word = chan_word_i[chan_q];

	////////////////////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			state_q      <= S_IDLE;
			chan_q       <= '0;
			phase_q      <= '0;
			count_q      <= '0;
			wr_en_q      <= 1'b0;
			frame_done_q <= 1'b0;
			buf_ctr_q    <= '0;
		end
		else
		begin
			state_q      <= state_d;
			chan_q       <= chan_d;
			phase_q      <= phase_d;
			count_q      <= count_d;
			wr_en_q      <= wr_en_d;
			frame_done_q <= inc_d;                  // lines up with the new count
			if (inc_d) buf_ctr_q <= buf_ctr_q + 1'b1;
		end
	end

	always_ff @(posedge adc_clk)
		if (wr_en_d) wr_data_o <= next_word;

	assign word_sel_o   = phase_q;    // shared by every snapshot
	assign wr_en_o      = wr_en_q;
	assign buf_ctr_o    = buf_ctr_q;
	assign frame_done_o = frame_done_q;

endmodule

//--- src/rx_snapshot.sv
// payload latch with 16-bit word select, shared by iq samples and ticks
`timescale 1ns/1ps

module rx_snapshot #(
	parameter type payload_t = rx_pkg::iq_sample_t
) (
	input  logic              adc_clk,
	input  logic              reset_bufs_A,
	input  logic              capture_i,   // sample-available strobe
	input  payload_t          payload_i,
	input  rx_pkg::word_sel_t word_sel_i,
	output rx_pkg::rx_word_t  word_o
);

	payload_t held_q;   // last captured payload
	logic     have_q;   // something captured since buffer reset
	payload_t cur;

	always_ff @(posedge adc_clk)
		if (capture_i) held_q <= payload_i;

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
			have_q <= 1'b0;
		else if (capture_i)
			have_q <= 1'b1;
	end

	// bypass in the strobe cycle so the sequencer can take word 0 straight away
	assign cur = capture_i ? payload_i : (have_q ? held_q : payload_t'(0));

	if (type(payload_t) == type(rx_pkg::iq_sample_t))
	begin : g_iq
		rx_pkg::iq_sample_t iq;
		assign iq = rx_pkg::iq_sample_t'(cur);

		always_comb
			case (word_sel_i)
				2'd0:    word_o = iq.i[15:0];
				2'd1:    word_o = iq.q[15:0];
				2'd2:    word_o = {iq.i[23:16], iq.q[23:16]};  // both high bytes in one word
				default: word_o = '0;
			endcase
	end
	else
	begin : g_ticks
		rx_pkg::ticks_t t;
		assign t = rx_pkg::ticks_t'(cur);

		always_comb
			case (word_sel_i)
				2'd0:    word_o = t[15:0];    // low word first
				2'd1:    word_o = t[31:16];
				2'd2:    word_o = t[47:32];
				default: word_o = '0;
			endcase
	end

endmodule

//--- src/rx_pkg.sv
// shared types: memory word, iq sample, ticks, word index, frame count, axi response
`include "rx_consts.svh"

package rx_pkg;

	// one word of the sample memory
	typedef logic [`RX_WORD_W-1:0] rx_word_t;

	// one receiver output, I in the upper half of the packed value
	typedef struct packed {
		logic [`RX_SAMP_W-1:0] i;
		logic [`RX_SAMP_W-1:0] q;
	} iq_sample_t;

	typedef logic [`RX_TICKS_W-1:0] ticks_t;   // latched at the sample strobe

	// picks one third of a 48-bit payload
	// value 3 has no payload word, the sequencer uses it for the counter word
	typedef logic [1:0] word_sel_t;

	typedef logic [`RX_NSAMPS_W-1:0] nsamps_t;  // transfers per frame

	// axi response codes
	typedef enum logic [1:0] {
		AXI_OKAY   = 2'b00,
		AXI_EXOKAY = 2'b01,
		AXI_SLVERR = 2'b10,
		AXI_DECERR = 2'b11
	} axi_resp_t;

endpackage

//--- include/rx_consts.svh
// receiver buffer constants: channel count, widths, memory depth, register map, reset defaults
`ifndef RX_CONSTS_SVH
`define RX_CONSTS_SVH

// datapath sizes
`define RX_NCHAN        2       // receiver channels packed per transfer
`define RX_WORD_W       16      // sample memory word
`define RX_SAMP_W       24      // one I or Q sample
`define RX_TICKS_W      48      // free-running tick counter
`define RX_NSAMPS_W     8       // transfers per frame register
`define RX_BUF_AW       8       // 256 words of sample memory

// axi4-lite slave port, the address reaches one window past the register map
`define RX_AXI_AW       5
`define RX_AXI_DW       32

// register byte offsets
`define RX_REG_NSAMPS   'h0     // transfers per frame, r/w
`define RX_REG_STATUS   'h4     // bit 0 service request, cleared on read
`define RX_REG_BUFCTR   'h8     // finished frame count
`define RX_REG_SAMPLE   'hC     // pop window into the sample memory

// values after reset
`define RX_NSAMPS_RESET 4

`endif
